/* flist.f */
logic/cipher_out_pkg.sv
logic/flex_fifo.sv
logic/encrypted_fifo.sv
logic/byte_uart_tx.sv
logic/cipher_out_top.sv
dv/cipher_out_asserts.sv
dv/cipher_out_tb.sv

/* Makefile */
TOP := cipher_out_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/cipher_out_tb.sv */
// ########################################
// Cipher output path testbench
// Directed tests with a serial receiver
// model checking every 8N1 frame
// ########################################
`timescale 1ns/1ps

module cipher_out_tb
	import cipher_out_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT + 1;
	localparam int BLOCK_CYCLES = BLOCK_BYTES * FRAME_CYCLES;
	// Seven blocks are sent in all, plus idle watches and margin
	localparam int TEST_BLOCKS    = 7;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_BLOCKS * BLOCK_CYCLES + 400;

	logic         clk;
	logic         n_rst;
	logic         complete;
	block_t       raw_data;
	logic         tx;
	logic         busy;
	fifo_status_t status;

	byte_t       rx_q[$];
	byte_t       exp_q[$];
	string       test_name;
	int          n_checks;
	int          n_errors;
	int          cycle_count;
	logic [31:0] rng;

	cipher_out_top cipher_out_top_inst (
		.clk      (clk),
		.n_rst    (n_rst),
		.complete (complete),
		.raw_data (raw_data),
		.tx       (tx),
		.busy     (busy),
		.status   (status)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check(input string what, input logic [7:0] expected, input logic [7:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic random_block(output block_t b);
		b = '0;
		repeat (4) begin
			rng = xorshift32(rng);
			b   = {b[95:0], rng};
		end
	endtask

	// One strobe cycle, driven just after the edge
	task automatic send_block(input block_t b, input logic expect_it);
		int i;
		@(posedge clk);
		#2;
		raw_data = b;
		complete = 1'b1;
		@(posedge clk);
		#2;
		complete = 1'b0;
		if (expect_it) begin
			// Top byte goes out first
			for (i = BLOCK_BYTES - 1; i >= 0; i--) begin
				exp_q.push_back(b[i * 8 +: 8]);
			end
		end
	endtask

	task automatic wait_busy_low();
		do @(negedge clk); while (busy);
	endtask

	// Samples mid-bit, start bit found on the first low level
	task automatic receive_byte(output byte_t data);
		int i;
		do @(negedge clk); while (tx !== 1'b0);
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		check("start bit", 8'h00, {7'b0, tx});
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			data[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		check("stop bit", 8'h01, {7'b0, tx});
	endtask

	task automatic compare_received();
		while (rx_q.size() < exp_q.size()) @(negedge clk);
		while (exp_q.size() > 0) begin
			check("rx byte", exp_q.pop_front(), rx_q.pop_front());
		end
	endtask

	task automatic test_reset_state();
		test_name = "reset_state";
		repeat (FRAME_CYCLES) begin
			@(negedge clk);
			check("tx", 8'h01, {7'b0, tx});
			check("busy", 8'h00, {7'b0, busy});
			check("empty", 8'h01, {7'b0, status.empty});
		end
	endtask

	task automatic test_single_block();
		test_name = "single_block";
		send_block(128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff, 1'b1);
		compare_received();
	endtask

	task automatic test_dropped_strobe();
		test_name = "dropped_strobe";
		send_block(128'hdead_beef_0102_0304_a5a5_5a5a_f00d_cafe, 1'b1);
		repeat (4) @(negedge clk);
		check("busy at 2nd strobe", 8'h01, {7'b0, busy});
		send_block(128'hffff_0000_ffff_0000_1234_5678_9abc_def0, 1'b0);
		compare_received();
		// Nothing more should leave the line
		repeat (2 * FRAME_CYCLES) begin
			@(negedge clk);
			check("idle tx", 8'h01, {7'b0, tx});
		end
		check("extra bytes", 8'h00, 8'(rx_q.size()));
		check("empty", 8'h01, {7'b0, status.empty});
	endtask

	task automatic test_back_to_back();
		test_name = "back_to_back";
		send_block(128'h8081_8283_8485_8687_8889_8a8b_8c8d_8e8f, 1'b1);
		wait_busy_low();
		send_block(128'h7f7e_7d7c_7b7a_7978_7776_7574_7372_7170, 1'b1);
		// First write of the second block fills the FIFO, serializer stalls
		repeat (2) @(negedge clk);
		check("fifo full", 8'h01, {7'b0, status.full});
		check("busy while stalled", 8'h01, {7'b0, busy});
		compare_received();
	endtask

	task automatic test_random_blocks();
		block_t b;
		test_name = "random_blocks";
		repeat (3) begin
			random_block(b);
			send_block(b, 1'b1);
			wait_busy_low();
		end
		compare_received();
	endtask

	initial begin
		byte_t data;
		wait (n_rst === 1'b1);
		forever begin
			receive_byte(data);
			rx_q.push_back(data);
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		n_rst     = 1'b0;
		complete  = 1'b0;
		raw_data  = '0;
		n_checks  = 0;
		n_errors  = 0;
		rng       = 32'd97;
		test_name = "setup";
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		n_rst = 1'b1;
		test_reset_state();
		test_single_block();
		test_dropped_strobe();
		test_back_to_back();
		test_random_blocks();
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* dv/cipher_out_asserts.sv */
// ########################################
// Cipher output path assertions
// FIFO flags, idle line, write and busy
// ########################################
`timescale 1ns/1ps

module cipher_out_asserts
	import cipher_out_pkg::*;
(
	input logic         clk,
	input logic         n_rst,
	input logic         tx,
	input logic         busy,
	input fifo_status_t status,
	input logic         w_enable,
	input tx_state_t    tx_state
);

	logic [15:0] busy_run;

	// Length of the current busy stretch
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy_run <= '0;
		end else if (busy) begin
			busy_run <= busy_run + 1'b1;
		end else begin
			busy_run <= '0;
		end
	end

	flags_exclusive: assert property (@(posedge clk) disable iff (!n_rst)
		!(status.full && status.empty))
		else $error("FIFO full and empty at once");

	idle_line_high: assert property (@(posedge clk) disable iff (!n_rst)
		(tx_state == TX_IDLE) |-> tx)
		else $error("Serial line low while transmitter idle");

	no_write_when_full: assert property (@(posedge clk) disable iff (!n_rst)
		w_enable |-> !status.full)
		else $error("FIFO written while full");

	// A whole block takes at least one write per byte
	busy_min_length: assert property (@(posedge clk) disable iff (!n_rst)
		$fell(busy) |-> (busy_run >= 16'(BLOCK_BYTES)))
		else $error("Serializer busy for fewer cycles than bytes in a block");

endmodule

bind cipher_out_top cipher_out_asserts cipher_out_asserts_inst (
	.clk      (clk),
	.n_rst    (n_rst),
	.tx       (tx),
	.busy     (busy),
	.status   (status),
	.w_enable (w_enable),
	.tx_state (byte_uart_tx_inst.state)
);

/* logic/cipher_out_top.sv */
// ########################################
// Cipher output path
// Block serializer, byte FIFO and UART
// transmitter onto one serial line
// ########################################
`timescale 1ns/1ps

module cipher_out_top
	import cipher_out_pkg::*;
(
	input  logic         clk,
	input  logic         n_rst,
	input  logic         complete,
	input  block_t       raw_data,
	output logic         tx,
	output logic         busy,
	output fifo_status_t status
);

	logic  w_enable;
	logic  r_enable;
	byte_t w_data;
	byte_t r_data;

	encrypted_fifo encrypted_fifo_inst (
		.clk      (clk),
		.n_rst    (n_rst),
		.complete (complete),
		.raw_data (raw_data),
		.status   (status),
		.w_enable (w_enable),
		.w_data   (w_data),
		.busy     (busy)
	);

	flex_fifo flex_fifo_inst (
		.clk      (clk),
		.n_rst    (n_rst),
		.r_enable (r_enable),
		.w_enable (w_enable),
		.w_data   (w_data),
		.r_data   (r_data),
		.status   (status)
	);

	byte_uart_tx byte_uart_tx_inst (
		.clk      (clk),
		.n_rst    (n_rst),
		.r_data   (r_data),
		.status   (status),
		.r_enable (r_enable),
		.tx       (tx)
	);

endmodule

/* logic/byte_uart_tx.sv */
// ########################################
// UART transmitter
// Pops FIFO bytes and sends 8N1 frames,
// LSB first, line high when idle
// ########################################
`timescale 1ns/1ps

module byte_uart_tx
	import cipher_out_pkg::*;
(
	input  logic         clk,
	input  logic         n_rst,
	input  byte_t        r_data,
	input  fifo_status_t status,
	output logic         r_enable,
	output logic         tx
);

	tx_state_t state;
	clk_cnt_t  clk_cnt;
	bit_idx_t  bit_idx;
	byte_t     tx_byte;
	logic      bit_done;

	// One pop per idle cycle with data waiting
	assign r_enable = (state == TX_IDLE) && !status.empty;
	assign bit_done = (clk_cnt == LAST_CLK);

	always_ff @(posedge clk) begin
		if (r_enable) begin
			tx_byte <= r_data;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (r_enable) begin
						state <= TX_START;
					end
				end
				TX_START: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (bit_done) begin
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (bit_done) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT) begin
							state <= TX_STOP;
						end
					end
				end
				TX_STOP: begin
					clk_cnt <= clk_cnt + 1'b1;
					// Back to idle for the one pop cycle
					if (bit_done) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Line level follows the frame position
	always_comb begin
		case (state)
			TX_START: tx = 1'b0;
			TX_DATA:  tx = tx_byte[bit_idx];
			default:  tx = 1'b1;
		endcase
	end

endmodule

/* logic/encrypted_fifo.sv */
// ########################################
// Block serializer
// Captures a ciphertext block and writes
// its bytes into the FIFO, MSB first
// ########################################
`timescale 1ns/1ps

module encrypted_fifo
	import cipher_out_pkg::*;
(
	input  logic         clk,
	input  logic         n_rst,
	input  logic         complete,
	input  block_t       raw_data,
	input  fifo_status_t status,
	output logic         w_enable,
	output byte_t        w_data,
	output logic         busy
);

	ser_state_t state;
	ser_state_t next_state;
	block_t     block;
	byte_idx_t  byte_idx;
	logic       accept;

	// Strobe is only taken in idle, otherwise dropped
	assign accept = (state == SER_IDLE) && complete;

	assign busy     = (state == SER_SHIFT);
	assign w_enable = (state == SER_SHIFT) && !status.full;

	// Byte 0 is the top byte of the block
	assign w_data = block[(BLOCK_BYTES - 1 - int'(byte_idx)) * $bits(byte_t) +: $bits(byte_t)];

	always_ff @(posedge clk) begin
		if (accept) begin
			block <= raw_data;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			SER_IDLE: begin
				if (complete) begin
					next_state = SER_SHIFT;
				end
			end
			SER_SHIFT: begin
				if (w_enable && (byte_idx == LAST_BYTE)) begin
					next_state = SER_IDLE;
				end
			end
			default: next_state = SER_IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= SER_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Index only moves on cycles that actually write
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			byte_idx <= '0;
		end else if (accept) begin
			byte_idx <= '0;
		end else if (w_enable) begin
			byte_idx <= byte_idx + 1'b1;
		end
	end

endmodule

/* logic/flex_fifo.sv */
// ########################################
// Byte FIFO
// Circular buffer with read/write strobes,
// head entry shown combinationally
// ########################################
`timescale 1ns/1ps

module flex_fifo
	import cipher_out_pkg::*;
(
	input  logic         clk,
	input  logic         n_rst,
	input  logic         r_enable,
	input  logic         w_enable,
	input  byte_t        w_data,
	output byte_t        r_data,
	output fifo_status_t status
);

	byte_t     mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fifo_cnt_t count;
	logic      do_write;
	logic      do_read;

	// Drop writes when full and reads when empty
	assign do_write = w_enable && !status.full;
	assign do_read  = r_enable && !status.empty;

	assign status.empty = (count == '0);
	assign status.full  = (count == FULL_CNT);

	// Head entry
	assign r_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= w_data;
		end
	end

	// Pointers wrap naturally at the buffer depth
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, unchanged on a simultaneous read and write
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			count <= '0;
		end else begin
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* logic/cipher_out_pkg.sv */
// ########################################
// Cipher output package
// Widths, FIFO sizing, serial bit timing,
// FIFO status struct and FSM encodings
// ########################################
package cipher_out_pkg;

	localparam int BLOCK_BYTES  = 16;
	localparam int FIFO_DEPTH   = 16;
	localparam int CLKS_PER_BIT = 4;
	localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

	typedef logic [127:0]                     block_t;
	typedef logic [7:0]                       byte_t;
	typedef logic [3:0]                       fifo_ptr_t;
	typedef logic [4:0]                       fifo_cnt_t;
	typedef logic [$clog2(BLOCK_BYTES)-1:0]   byte_idx_t;
	typedef logic [CLK_CNT_W-1:0]             clk_cnt_t;
	typedef logic [2:0]                       bit_idx_t;

	// Last values of the serializer and transmitter counters
	localparam byte_idx_t LAST_BYTE = byte_idx_t'(BLOCK_BYTES - 1);
	localparam clk_cnt_t  LAST_CLK  = clk_cnt_t'(CLKS_PER_BIT - 1);
	localparam bit_idx_t  LAST_BIT  = bit_idx_t'($bits(byte_t) - 1);
	localparam fifo_cnt_t FULL_CNT  = fifo_cnt_t'(FIFO_DEPTH);

	typedef struct packed {
		logic empty;
		logic full;
	} fifo_status_t;

	typedef enum logic {SER_IDLE, SER_SHIFT} ser_state_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage
